// ==== rv_decoder_vectors.txt ====
# id instr new ill_c | alu op_a op_b imm_b | rf_we d_req d_we d_type | csr_op flush illegal
# jump_set branch sys{ecall,ebrk,mret,dret,wfi} upper_reg, all hex, text after the last field ignored
01 fff10093 1 0 00 0 1 0 1 0 0 0 0 0 0 0 0 00 0  # addi x1, x2, -1
02 40335293 1 0 07 0 1 0 1 0 0 0 0 0 0 0 0 00 0  # srai x5, x6, 3
03 40109093 1 0 05 0 1 0 0 0 0 0 0 0 1 0 0 00 0  # slli with funct7 0x20
04 009403b3 1 0 00 0 0 0 1 0 0 0 0 0 0 0 0 00 0  # add x7, x8, x9
05 40c58533 1 0 01 0 0 0 1 0 0 0 0 0 0 0 0 00 0  # sub x10, x11, x12
06 023100b3 1 0 09 0 0 0 0 0 0 0 0 0 1 0 0 00 0  # mul pattern, no rv32m
07 008000ef 1 0 00 1 1 4 0 0 0 0 0 0 0 1 0 00 0  # jal x1, +8 first phase
08 008000ef 0 0 00 1 1 5 1 0 0 0 0 0 0 0 0 00 0  # jal link phase
09 004100e7 1 0 00 0 1 0 0 0 0 0 0 0 0 1 0 00 0  # jalr x1, 4(x2) first phase
0a 004100e7 0 0 00 1 1 5 1 0 0 0 0 0 0 0 0 00 0  # jalr link phase
0b 00208863 1 0 0a 0 0 0 0 0 0 0 0 0 0 0 1 00 0  # beq x1, x2, +16
0c 0020a863 1 0 09 0 0 0 0 0 0 0 0 0 1 0 0 00 0  # branch funct3 2
0d 0020e863 0 0 00 1 1 2 0 0 0 0 0 0 0 0 1 00 0  # bltu target phase
0e 00030283 1 0 00 0 1 0 1 1 0 2 0 0 0 0 0 00 0  # lb x5, 0(x6)
0f 00235283 1 0 00 0 1 0 1 1 0 1 0 0 0 0 0 00 0  # lhu x5, 2(x6)
10 00036283 1 0 00 0 1 0 0 0 0 0 0 0 1 0 0 00 0  # lwu
11 00742423 1 0 00 0 1 1 0 1 1 0 0 0 0 0 0 00 0  # sw x7, 8(x8)
12 00743423 1 0 00 0 1 1 0 0 0 0 0 0 1 0 0 00 0  # store funct3 3
13 00740423 1 1 00 0 1 1 0 0 0 2 0 0 1 0 0 00 0  # sb from a bad compressed word
14 000f82b7 1 0 00 2 1 3 1 0 0 0 0 0 0 0 0 00 0  # lui x5, 0xf8
15 340020f3 1 0 09 0 1 0 1 0 0 0 0 0 0 0 0 00 0  # csrrs x1, mscratch, x0
16 340120f3 1 0 09 0 1 0 1 0 0 0 2 0 0 0 0 00 0  # csrrs x1, mscratch, x2
17 30029073 1 0 09 0 1 0 1 0 0 0 1 1 0 0 0 00 0  # csrrw x0, mstatus, x5
18 7b133073 1 0 09 0 1 0 1 0 0 0 3 1 0 0 0 00 0  # csrrc x0, dpc, x6
19 00000073 1 0 09 0 1 0 0 0 0 0 0 0 0 0 0 10 0  # ecall
1a 00100073 1 0 09 0 1 0 0 0 0 0 0 0 0 0 0 08 0  # ebreak
1b 30200073 1 0 09 0 1 0 0 0 0 0 0 0 0 0 0 04 0  # mret
1c 7b200073 1 0 09 0 1 0 0 0 0 0 0 0 0 0 0 02 0  # dret
1d 10500073 1 0 09 0 1 0 0 0 0 0 0 0 0 0 0 01 0  # wfi
1e 000000f3 1 0 09 0 1 0 0 0 0 0 0 0 1 0 0 10 0  # ecall with rd = x1
1f 002088b3 1 0 00 0 0 0 1 0 0 0 0 0 0 0 0 00 1  # add x17, x1, x2
20 0000100f 1 0 00 1 1 5 0 0 0 0 0 0 0 1 0 00 0  # fence.i first phase
21 0000007f 1 0 09 2 1 0 0 0 0 0 0 0 1 0 0 00 0  # unknown opcode

// ==== compile.f ====
+incdir+.
rv_dec_pkg.sv
rv_imm_extract.sv
rv_opcode_decode.sv
rv_illegal_gate.sv
rv_csr_ctrl.sv
rv_decoder_top.sv
tb_rv_decoder.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_decoder
RTL_TOP   ?= rv_decoder_top
RV32E     ?= 0
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) -GRV32E=$(RV32E) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) --lint-only -Wall -f compile.f --top-module $(RTL_TOP) -GRV32E=$(RV32E)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_rv_decoder.sv ====
// rv32 decoder testbench
// replays the decode vectors against the decoder top level and
// checks control, csr, trap flags, immediates and register fields
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decoder
  import rv_dec_pkg::*;
#(
  parameter bit RV32E = 1'b0
);

  localparam int    HALF_PERIOD  = 5;     // 10 ns clock
  localparam int    RESET_CYCLES = 8;
  localparam string VEC_FILE     = "rv_decoder_vectors.txt";

  // one row of the vector file
  typedef struct packed {
    logic [7:0]  id;
    logic [31:0] instr;
    logic        inew;
    logic        ic;
    logic [4:0]  alu;
    logic [1:0]  opa;
    logic        opb;
    logic [2:0]  immb;
    logic        we;
    logic        req;
    logic        dwe;
    logic [1:0]  dt;
    logic [1:0]  csr;
    logic        fl;
    logic        ill;
    logic        js;
    logic        br;
    logic [4:0]  sys;
    logic        up;      // row names a register above x15
  } vec_t;

  logic        clk;
  logic        arst_n;
  logic [31:0] instr_rdata;
  logic        instr_new;
  logic        illegal_c;
  dec_ctrl_t   ctrl;
  imm_set_t    imm;
  reg_addr_t   regs;
  sys_flags_t  sys;
  csr_op_e     csr_op;
  logic        csr_flush;
  logic        illegal;

  vec_t vecs[$];
  logic load_error = 1'b0;
  int   row_errors = 0;
  int   limit      = 0;   // set once the rows are known
  int   cycles     = 0;

  rv_decoder_top #(
    .RV32E (RV32E)
  ) u_rv_decoder_top (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .instr_rdata_i    (instr_rdata),
    .instr_new_i      (instr_new),
    .illegal_c_insn_i (illegal_c),
    .ctrl_o           (ctrl),
    .imm_o            (imm),
    .regs_o           (regs),
    .sys_o            (sys),
    .csr_op_o         (csr_op),
    .csr_pipe_flush_o (csr_flush),
    .illegal_insn_o   (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // cycle budget, rows + reset + slack
  initial begin
    while (limit == 0 || cycles <= limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the vectors did not finish", cycles);
    $display(">>> FAIL");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
      row_errors++;
    end
  endtask

  // immediate layouts as the isa defines them
  function automatic imm_set_t spec_imm(input logic [31:0] ins);
    logic signed [11:0] i12;
    logic signed [11:0] s12;
    logic signed [12:0] b13;
    logic signed [20:0] j21;
    imm_set_t           r;
    i12    = ins[31:20];
    s12    = {ins[31:25], ins[11:7]};
    b13    = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    j21    = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    r.i    = 32'(i12);
    r.s    = 32'(s12);
    r.b    = 32'(b13);
    r.j    = 32'(j21);
    r.u    = {ins[31:12], 12'h000};
    r.zimm = 32'(ins[19:15]);  // unsigned
    return r;
  endfunction

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [0:18];
    vec_t        v;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the vector file %s", VEC_FILE);
      load_error = 1'b1;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == "#") continue;  // blank or column notes
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
        if (n != 19) begin
          $display("malformed vector line: %s", line);
          load_error = 1'b1;
        end else begin
          v.id   = f[0][7:0];
          v.instr = f[1];
          v.inew = f[2][0];
          v.ic   = f[3][0];
          v.alu  = f[4][4:0];
          v.opa  = f[5][1:0];
          v.opb  = f[6][0];
          v.immb = f[7][2:0];
          v.we   = f[8][0];
          v.req  = f[9][0];
          v.dwe  = f[10][0];
          v.dt   = f[11][1:0];
          v.csr  = f[12][1:0];
          v.fl   = f[13][0];
          v.ill  = f[14][0];
          v.js   = f[15][0];
          v.br   = f[16][0];
          v.sys  = f[17][4:0];
          v.up   = f[18][0];
          vecs.push_back(v);
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    vec_t       v;
    imm_set_t   ei;
    logic       rv32e_hit;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       is_csr;
    logic       is_jump;
    int         passed;
    int         failed;
    passed      = 0;
    failed      = 0;
    arst_n      = 1'b0;
    instr_rdata = 32'h0000_0013;   // addi x0, x0, 0
    instr_new   = 1'b0;
    illegal_c   = 1'b0;
    load_vectors();
    limit = vecs.size() + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;

    //////////////////////////////
    // one row per cycle
    //////////////////////////////
    foreach (vecs[k]) begin
      v = vecs[k];
      @(negedge clk);
      instr_rdata = v.instr;
      instr_new   = v.inew;
      illegal_c   = v.ic;
      #(HALF_PERIOD - 1);          // settled, just before posedge
      row_errors = 0;
      rv32e_hit  = RV32E && v.up;  // upper register on rv32e
      opc        = v.instr[6:0];
      f3         = v.instr[14:12];
      check_val("alu_operator", 32'(ctrl.alu_operator), 32'(v.alu));
      check_val("op_a_sel", 32'(ctrl.op_a_sel), 32'(v.opa));
      check_val("op_b_sel", 32'(ctrl.op_b_sel), 32'(v.opb));
      check_val("imm_b_sel", 32'(ctrl.imm_b_sel), 32'(v.immb));
      check_val("regfile_we", 32'(ctrl.regfile_we), 32'(v.we && !rv32e_hit));
      check_val("data_req", 32'(ctrl.data_req), 32'(v.req));
      check_val("data_we", 32'(ctrl.data_we), 32'(v.dwe));
      check_val("data_type", 32'(ctrl.data_type), 32'(v.dt));
      check_val("csr_op", 32'(csr_op), 32'(v.csr));
      check_val("csr_pipe_flush", 32'(csr_flush), 32'(v.fl));
      check_val("illegal_insn", 32'(illegal), 32'(v.ill || rv32e_hit));
      check_val("jump_set", 32'(ctrl.jump_set), 32'(v.js));
      check_val("branch_in_dec", 32'(ctrl.branch_in_dec), 32'(v.br));
      check_val("sys_flags", 32'(sys), 32'(v.sys));
      // fields without a vector column, from the opcode class
      is_csr  = (opc == 7'h73) && (f3 != 3'b000);
      is_jump = (opc == 7'h6f) || (opc == 7'h67) || (opc == 7'h0f && f3 == 3'b001);
      check_val("jump_in_dec", 32'(ctrl.jump_in_dec), 32'(is_jump && !v.ill));
      check_val("csr_access", 32'(ctrl.csr_access), 32'(is_csr && !v.ill));
      check_val("rf_wdata_sel", 32'(ctrl.rf_wdata_sel),
                is_csr ? 32'(RF_WD_CSR) : (opc == 7'h03) ? 32'(RF_WD_LSU) : 32'(RF_WD_EX));
      check_val("imm_a_sel", 32'(ctrl.imm_a_sel), is_csr ? 32'(IMM_A_Z) : 32'(IMM_A_ZERO));
      // lb, lh and lw sign extend, lbu and lhu do not
      if (opc == 7'h03 && !v.ill)
        check_val("data_sign_ext", 32'(ctrl.data_sign_ext),
                  32'(f3 inside {3'b000, 3'b001, 3'b010}));
      ei = spec_imm(v.instr);
      check_val("imm_i", imm.i, ei.i);
      check_val("imm_s", imm.s, ei.s);
      check_val("imm_b", imm.b, ei.b);
      check_val("imm_u", imm.u, ei.u);
      check_val("imm_j", imm.j, ei.j);
      check_val("imm_zimm", imm.zimm, ei.zimm);
      check_val("raddr_a", 32'(regs.raddr_a), 32'(v.instr[19:15]));
      check_val("raddr_b", 32'(regs.raddr_b), 32'(v.instr[24:20]));
      check_val("waddr", 32'(regs.waddr), 32'(v.instr[11:7]));
      if (row_errors == 0) begin
        passed++;
        $display("test %02h ok", v.id);
      end else begin
        failed++;
        $display("test %02h bad, %0d mismatches", v.id, row_errors);
      end
    end

    $display("tests ok %0d, tests failed %0d", passed, failed);
    if (failed == 0 && !load_error && vecs.size() > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_decoder_top.sv ====
// rv32 instruction decoder, top level
// combinational decode of one instruction word into immediates,
// register addresses, control, csr operation and trap flags
`timescale 1ns/1ps
`default_nettype none
`include "rv_dec_consts.svh"

module rv_decoder_top
  import rv_dec_pkg::*;
#(
  parameter bit RV32E = 1'b0
) (
  input  logic                clk_i,             // assertions only
  input  logic                arst_n_i,
  input  logic [`RV_XLEN-1:0] instr_rdata_i,
  input  logic                instr_new_i,
  input  logic                illegal_c_insn_i,
  output dec_ctrl_t           ctrl_o,
  output imm_set_t            imm_o,
  output reg_addr_t           regs_o,
  output sys_flags_t          sys_o,
  output csr_op_e             csr_op_o,
  output logic                csr_pipe_flush_o,
  output logic                illegal_insn_o
);

  dec_ctrl_t ctrl_raw;       // before illegal masking
  csr_op_e   csr_op_raw;
  logic      decode_illegal;

  rv_imm_extract u_rv_imm_extract (
    .instr_i (instr_rdata_i),
    .imm_o   (imm_o),
    .regs_o  (regs_o)
  );

  rv_opcode_decode u_rv_opcode_decode (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .instr_i     (instr_rdata_i),
    .instr_new_i (instr_new_i),
    .ctrl_o      (ctrl_raw),
    .csr_op_o    (csr_op_raw),
    .sys_o       (sys_o),
    .illegal_o   (decode_illegal)
  );

  rv_illegal_gate #(
    .RV32E (RV32E)
  ) u_rv_illegal_gate (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .ctrl_i           (ctrl_raw),
    .regs_i           (regs_o),
    .decode_illegal_i (decode_illegal),
    .illegal_c_insn_i (illegal_c_insn_i),
    .ctrl_o           (ctrl_o),
    .illegal_insn_o   (illegal_insn_o)
  );

  // gated access bit, so illegal words never flush
  rv_csr_ctrl u_rv_csr_ctrl (
    .instr_i          (instr_rdata_i),
    .csr_access_i     (ctrl_o.csr_access),
    .csr_op_i         (csr_op_raw),
    .csr_op_o         (csr_op_o),
    .csr_pipe_flush_o (csr_pipe_flush_o)
  );

endmodule

`default_nettype wire

// ==== rv_csr_ctrl.sv ====
// csr operation and flush control
// downgrades set/clear with a zero source to a read and flags
// the csr writes that need a pipeline flush
`timescale 1ns/1ps
`default_nettype none
`include "rv_dec_consts.svh"

module rv_csr_ctrl
  import rv_dec_pkg::*;
(
  input  logic [`RV_XLEN-1:0] instr_i,
  input  logic                csr_access_i,    // already gated
  input  csr_op_e             csr_op_i,
  output csr_op_e             csr_op_o,
  output logic                csr_pipe_flush_o
);

  logic [11:0] csr_addr;
  logic        irq_csr;     // mstatus or mie
  logic        dbg_csr;     // debug csrs
  logic        wr_or_set;

  assign csr_addr = instr_i[`RV_FUNCT12];

  // set or clear from x0 or uimm 0 writes nothing
  always_comb begin
    csr_op_o = csr_op_i;
    if ((csr_op_i == CSR_OP_SET || csr_op_i == CSR_OP_CLEAR) &&
        instr_i[`RV_RS1] == '0) begin
      csr_op_o = CSR_OP_READ;
    end
  end

  assign irq_csr = (csr_addr == `RV_CSR_MSTATUS) || (csr_addr == `RV_CSR_MIE);
  assign dbg_csr = (csr_addr == `RV_CSR_DCSR)      || (csr_addr == `RV_CSR_DPC) ||
                   (csr_addr == `RV_CSR_DSCRATCH0) || (csr_addr == `RV_CSR_DSCRATCH1);

  assign wr_or_set = (csr_op_o == CSR_OP_WRITE) || (csr_op_o == CSR_OP_SET);

  // enabling irqs needs a flush so the controller sees pending ones
  // on the next cycle, debug csr changes flush unconditionally
  assign csr_pipe_flush_o = csr_access_i &
                            ((wr_or_set & irq_csr) |
                             ((csr_op_o != CSR_OP_READ) & dbg_csr));

endmodule

`default_nettype wire

// ==== rv_illegal_gate.sv ====
// illegal instruction gate
// merges decode and compressed illegal flags, runs the rv32e
// register check and masks every side-effecting enable
`timescale 1ns/1ps
`default_nettype none

module rv_illegal_gate
  import rv_dec_pkg::*;
#(
  parameter bit RV32E = 1'b0
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  dec_ctrl_t ctrl_i,
  input  reg_addr_t regs_i,
  input  logic      decode_illegal_i,
  input  logic      illegal_c_insn_i,   // from the compressed expander
  output dec_ctrl_t ctrl_o,
  output logic      illegal_insn_o
);

  logic      illegal_dec;
  logic      illegal_rv32e;
  dec_ctrl_t ctrl_gated;

  assign illegal_dec = decode_illegal_i | illegal_c_insn_i;

  always_comb begin
    ctrl_gated = ctrl_i;
    if (illegal_dec) begin  // nothing may reach rf, lsu, pc or csrs
      ctrl_gated.regfile_we    = 1'b0;
      ctrl_gated.data_req      = 1'b0;
      ctrl_gated.data_we       = 1'b0;
      ctrl_gated.jump_in_dec   = 1'b0;
      ctrl_gated.jump_set      = 1'b0;
      ctrl_gated.branch_in_dec = 1'b0;
      ctrl_gated.csr_access    = 1'b0;
    end
  end

  //////////////////////////////
  // rv32e register check
  //////////////////////////////
  if (RV32E) begin : gen_rv32e_check
    // only x0..x15 exist
    assign illegal_rv32e = (regs_i.raddr_a[4] & (ctrl_gated.op_a_sel == OP_A_REG_A)) |
                           (regs_i.raddr_b[4] & (ctrl_gated.op_b_sel == OP_B_REG_B)) |
                           (regs_i.waddr[4]   & ctrl_gated.regfile_we);
  end else begin : gen_no_rv32e_check
    assign illegal_rv32e = 1'b0;
  end

  always_comb begin
    ctrl_o            = ctrl_gated;
    ctrl_o.regfile_we = ctrl_gated.regfile_we & ~illegal_rv32e;  // only we is masked
  end

  assign illegal_insn_o = illegal_dec | illegal_rv32e;

  // both illegal sources must keep the regfile untouched
  a_illegal_no_we : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    illegal_insn_o |-> !ctrl_o.regfile_we);

endmodule

`default_nettype wire

// ==== rv_opcode_decode.sv ====
// rv32i opcode decode
// one case over the major opcode gives the raw control word, the raw
// csr operation, the trap flags and the decode-illegal flag
// clock and reset only clock the assertion
`timescale 1ns/1ps
`default_nettype none
`include "rv_dec_consts.svh"

module rv_opcode_decode
  import rv_dec_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic [`RV_XLEN-1:0] instr_i,
  input  logic               instr_new_i,   // first cycle of this instruction
  output dec_ctrl_t          ctrl_o,
  output csr_op_e            csr_op_o,
  output sys_flags_t         sys_o,
  output logic               illegal_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcode_e'(instr_i[`RV_OPCODE]);
  assign funct3 = instr_i[`RV_FUNCT3];
  assign funct7 = instr_i[`RV_FUNCT7];

  always_comb begin
    ctrl_o              = '0;           // enables low
    ctrl_o.alu_operator = ALU_SLTU;
    ctrl_o.op_a_sel     = OP_A_IMM;
    ctrl_o.op_b_sel     = OP_B_IMM;
    ctrl_o.imm_a_sel    = IMM_A_ZERO;
    ctrl_o.imm_b_sel    = IMM_B_I;
    ctrl_o.rf_wdata_sel = RF_WD_EX;
    ctrl_o.data_type    = DT_WORD;
    csr_op_o            = CSR_OP_READ;
    sys_o               = '0;
    illegal_o           = 1'b0;

    unique case (opcode)
      //////////////////////////////
      // jumps and branches
      //////////////////////////////
      OPCODE_JAL: begin
        ctrl_o.jump_in_dec  = 1'b1;
        ctrl_o.op_a_sel     = OP_A_CURRPC;
        ctrl_o.alu_operator = ALU_ADD;
        if (instr_new_i) begin            // pc + j imm
          ctrl_o.imm_b_sel = IMM_B_J;
          ctrl_o.jump_set  = 1'b1;
        end else begin                    // link value pc + 4
          ctrl_o.imm_b_sel  = IMM_B_INCR_PC;
          ctrl_o.regfile_we = 1'b1;
        end
      end

      OPCODE_JALR: begin
        ctrl_o.jump_in_dec  = 1'b1;
        ctrl_o.alu_operator = ALU_ADD;
        if (instr_new_i) begin            // rs1 + i imm
          ctrl_o.op_a_sel = OP_A_REG_A;
          ctrl_o.jump_set = 1'b1;
        end else begin
          ctrl_o.op_a_sel   = OP_A_CURRPC;
          ctrl_o.imm_b_sel  = IMM_B_INCR_PC;
          ctrl_o.regfile_we = 1'b1;
        end
        if (funct3 != 3'b000) illegal_o = 1'b1;
      end

      OPCODE_BRANCH: begin
        ctrl_o.branch_in_dec = 1'b1;
        unique case (funct3)
          3'b000:  ctrl_o.alu_operator = ALU_EQ;
          3'b001:  ctrl_o.alu_operator = ALU_NE;
          3'b100:  ctrl_o.alu_operator = ALU_LT;
          3'b101:  ctrl_o.alu_operator = ALU_GE;
          3'b110:  ctrl_o.alu_operator = ALU_LTU;
          3'b111:  ctrl_o.alu_operator = ALU_GEU;
          default: illegal_o = 1'b1;      // 010 and 011
        endcase
        if (instr_new_i) begin            // condition from rs1 vs rs2
          ctrl_o.op_a_sel = OP_A_REG_A;
          ctrl_o.op_b_sel = OP_B_REG_B;
        end else begin                    // target in the next phase
          ctrl_o.op_a_sel     = OP_A_CURRPC;
          ctrl_o.imm_b_sel    = IMM_B_B;
          ctrl_o.alu_operator = ALU_ADD;
        end
      end

      //////////////////////////////
      // loads and stores
      //////////////////////////////
      OPCODE_STORE: begin
        ctrl_o.op_a_sel     = OP_A_REG_A;
        ctrl_o.imm_b_sel    = IMM_B_S;    // address = rs1 + s imm
        ctrl_o.alu_operator = ALU_ADD;
        ctrl_o.data_req     = 1'b1;
        ctrl_o.data_we      = 1'b1;
        if (instr_i[14]) illegal_o = 1'b1;
        unique case (funct3[1:0])
          2'b00:   ctrl_o.data_type = DT_BYTE;
          2'b01:   ctrl_o.data_type = DT_HALF;
          2'b10:   ctrl_o.data_type = DT_WORD;
          default: illegal_o = 1'b1;
        endcase
      end

      OPCODE_LOAD: begin
        ctrl_o.op_a_sel      = OP_A_REG_A;
        ctrl_o.alu_operator  = ALU_ADD;
        ctrl_o.rf_wdata_sel  = RF_WD_LSU;
        ctrl_o.regfile_we    = 1'b1;
        ctrl_o.data_req      = 1'b1;
        ctrl_o.data_sign_ext = ~instr_i[14];   // lbu/lhu zero extend
        unique case (funct3[1:0])
          2'b00: ctrl_o.data_type = DT_BYTE;
          2'b01: ctrl_o.data_type = DT_HALF;
          2'b10: begin
            ctrl_o.data_type = DT_WORD;
            if (instr_i[14]) illegal_o = 1'b1; // no lwu on rv32
          end
          default: illegal_o = 1'b1;
        endcase
      end

      //////////////////////////////
      // alu
      //////////////////////////////
      OPCODE_LUI: begin                   // zero + u imm
        ctrl_o.imm_b_sel    = IMM_B_U;
        ctrl_o.alu_operator = ALU_ADD;
        ctrl_o.regfile_we   = 1'b1;
      end

      OPCODE_AUIPC: begin
        ctrl_o.op_a_sel     = OP_A_CURRPC;
        ctrl_o.imm_b_sel    = IMM_B_U;
        ctrl_o.alu_operator = ALU_ADD;
        ctrl_o.regfile_we   = 1'b1;
      end

      OPCODE_OP_IMM: begin
        ctrl_o.op_a_sel   = OP_A_REG_A;
        ctrl_o.regfile_we = 1'b1;
        unique case (funct3)
          3'b000: ctrl_o.alu_operator = ALU_ADD;
          3'b010: ctrl_o.alu_operator = ALU_SLT;
          3'b011: ctrl_o.alu_operator = ALU_SLTU;
          3'b100: ctrl_o.alu_operator = ALU_XOR;
          3'b110: ctrl_o.alu_operator = ALU_OR;
          3'b111: ctrl_o.alu_operator = ALU_AND;
          3'b001: begin
            ctrl_o.alu_operator = ALU_SLL;
            if (funct7 != `RV_F7_BASE) illegal_o = 1'b1;
          end
          default: begin                  // 101, srli or srai
            if (funct7 == `RV_F7_BASE) begin
              ctrl_o.alu_operator = ALU_SRL;
            end else if (funct7 == `RV_F7_ALT) begin
              ctrl_o.alu_operator = ALU_SRA;
            end else begin
              illegal_o = 1'b1;
            end
          end
        endcase
      end

      OPCODE_OP: begin
        ctrl_o.op_a_sel   = OP_A_REG_A;
        ctrl_o.op_b_sel   = OP_B_REG_B;
        ctrl_o.regfile_we = 1'b1;
        // bit 31 set and the muldiv funct7 land in default
        unique case ({funct7, funct3})
          {`RV_F7_BASE, 3'b000}: ctrl_o.alu_operator = ALU_ADD;
          {`RV_F7_ALT,  3'b000}: ctrl_o.alu_operator = ALU_SUB;
          {`RV_F7_BASE, 3'b010}: ctrl_o.alu_operator = ALU_SLT;
          {`RV_F7_BASE, 3'b011}: ctrl_o.alu_operator = ALU_SLTU;
          {`RV_F7_BASE, 3'b100}: ctrl_o.alu_operator = ALU_XOR;
          {`RV_F7_BASE, 3'b110}: ctrl_o.alu_operator = ALU_OR;
          {`RV_F7_BASE, 3'b111}: ctrl_o.alu_operator = ALU_AND;
          {`RV_F7_BASE, 3'b001}: ctrl_o.alu_operator = ALU_SLL;
          {`RV_F7_BASE, 3'b101}: ctrl_o.alu_operator = ALU_SRL;
          {`RV_F7_ALT,  3'b101}: ctrl_o.alu_operator = ALU_SRA;
          default:               illegal_o = 1'b1;
        endcase
      end

      //////////////////////////////
      // fence and system
      //////////////////////////////
      OPCODE_MISC_MEM: begin
        unique case (funct3)
          3'b000: begin                   // fence runs as a nop
            ctrl_o.op_a_sel     = OP_A_REG_A;
            ctrl_o.alu_operator = ALU_ADD;
          end
          3'b001: begin
            // fence.i jumps to pc + 4 so fetch gets flushed
            ctrl_o.jump_in_dec  = 1'b1;
            ctrl_o.jump_set     = instr_new_i;
            ctrl_o.op_a_sel     = OP_A_CURRPC;
            ctrl_o.imm_b_sel    = IMM_B_INCR_PC;
            ctrl_o.alu_operator = ALU_ADD;
          end
          default: illegal_o = 1'b1;
        endcase
      end

      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin       // traps and returns
          ctrl_o.op_a_sel = OP_A_REG_A;
          unique case (instr_i[`RV_FUNCT12])
            `RV_F12_ECALL:  sys_o.ecall = 1'b1;
            `RV_F12_EBREAK: sys_o.ebrk  = 1'b1;
            `RV_F12_MRET:   sys_o.mret  = 1'b1;
            `RV_F12_DRET:   sys_o.dret  = 1'b1;
            `RV_F12_WFI:    sys_o.wfi   = 1'b1;
            default:        illegal_o   = 1'b1;
          endcase
          if (instr_i[`RV_RS1] != '0 || instr_i[`RV_RD] != '0) illegal_o = 1'b1;
        end else begin                    // csr read/modify
          ctrl_o.csr_access   = 1'b1;
          ctrl_o.rf_wdata_sel = RF_WD_CSR;
          ctrl_o.regfile_we   = 1'b1;
          ctrl_o.imm_a_sel    = IMM_A_Z;
          ctrl_o.op_a_sel     = instr_i[14] ? OP_A_IMM : OP_A_REG_A;  // uimm forms
          unique case (funct3[1:0])
            2'b01:   csr_op_o  = CSR_OP_WRITE;
            2'b10:   csr_op_o  = CSR_OP_SET;
            2'b11:   csr_op_o  = CSR_OP_CLEAR;
            default: illegal_o = 1'b1;
          endcase
        end
      end

      default: illegal_o = 1'b1;          // unknown opcode
    endcase
  end

  // funct3 feeds the op-imm case unqualified
  a_op_imm_funct3_known : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (opcode == OPCODE_OP_IMM) |-> !$isunknown(funct3));

endmodule

`default_nettype wire

// ==== rv_imm_extract.sv ====
// immediate and register field extraction
// builds all immediate formats and the register addresses
// straight from the instruction word
`timescale 1ns/1ps
`default_nettype none
`include "rv_dec_consts.svh"

module rv_imm_extract
  import rv_dec_pkg::*;
(
  input  logic [`RV_XLEN-1:0] instr_i,
  output imm_set_t            imm_o,
  output reg_addr_t           regs_o
);

  logic sign;  // every signed format takes bit 31

  assign sign = instr_i[31];

  // sign extended formats
  assign imm_o.i = {{20{sign}}, instr_i[31:20]};
  assign imm_o.s = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
  assign imm_o.b = {{19{sign}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
  assign imm_o.j = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  assign imm_o.u    = {instr_i[31:12], 12'b0};            // upper 20, low zeros
  assign imm_o.zimm = {27'b0, instr_i[`RV_RS1]};          // rs1 field as uimm

  assign regs_o.raddr_a = instr_i[`RV_RS1];
  assign regs_o.raddr_b = instr_i[`RV_RS2];
  assign regs_o.waddr   = instr_i[`RV_RD];

endmodule

`default_nettype wire

// ==== rv_dec_pkg.sv ====
// rv32 decoder types
// enums for opcodes, alu operations and mux selects, and the
// structs that carry the decode results between blocks
`default_nettype none
`include "rv_dec_consts.svh"

package rv_dec_pkg;

  typedef enum logic [6:0] {
    OPCODE_LOAD     = `RV_OPC_LOAD,
    OPCODE_MISC_MEM = `RV_OPC_MISC_MEM,
    OPCODE_OP_IMM   = `RV_OPC_OP_IMM,
    OPCODE_AUIPC    = `RV_OPC_AUIPC,
    OPCODE_STORE    = `RV_OPC_STORE,
    OPCODE_OP       = `RV_OPC_OP,
    OPCODE_LUI      = `RV_OPC_LUI,
    OPCODE_BRANCH   = `RV_OPC_BRANCH,
    OPCODE_JALR     = `RV_OPC_JALR,
    OPCODE_JAL      = `RV_OPC_JAL,
    OPCODE_SYSTEM   = `RV_OPC_SYSTEM
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB,
    ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU  // branch compares
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_IMM} op_a_sel_e;
  typedef enum logic       {OP_B_REG_B, OP_B_IMM} op_b_sel_e;
  typedef enum logic       {IMM_A_Z, IMM_A_ZERO} imm_a_sel_e;   // zimm or zero

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  typedef enum logic [1:0] {RF_WD_EX, RF_WD_LSU, RF_WD_CSR} rf_wd_sel_e;

  typedef enum logic [1:0] {
    CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR
  } csr_op_e;

  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

  //////////////////////////////
  // decode result structs
  //////////////////////////////

  typedef struct packed {
    logic [`RV_XLEN-1:0] i;
    logic [`RV_XLEN-1:0] s;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] u;
    logic [`RV_XLEN-1:0] j;
    logic [`RV_XLEN-1:0] zimm;   // csr immediate, zero extended
  } imm_set_t;

  typedef struct packed {
    logic [`RV_REG_AW-1:0] raddr_a;
    logic [`RV_REG_AW-1:0] raddr_b;
    logic [`RV_REG_AW-1:0] waddr;
  } reg_addr_t;

  typedef struct packed {
    alu_op_e    alu_operator;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_a_sel_e imm_a_sel;
    imm_b_sel_e imm_b_sel;
    rf_wd_sel_e rf_wdata_sel;
    logic       regfile_we;
    logic       data_req;       // lsu request
    logic       data_we;
    data_type_e data_type;
    logic       data_sign_ext;
    logic       jump_in_dec;
    logic       jump_set;
    logic       branch_in_dec;
    logic       csr_access;
  } dec_ctrl_t;

  typedef struct packed {
    logic ecall;
    logic ebrk;
    logic mret;
    logic dret;
    logic wfi;
  } sys_flags_t;

endpackage

`default_nettype wire

// ==== rv_dec_consts.svh ====
// rv32 decoder constants
// instruction field positions, major opcodes, funct codes and the
// csr addresses that the flush rule looks at
`ifndef RV_DEC_CONSTS_SVH
`define RV_DEC_CONSTS_SVH

`define RV_XLEN    32
`define RV_REG_AW  5            // register address width

// instruction fields
`define RV_RS1     19:15
`define RV_RS2     24:20
`define RV_RD      11:7
`define RV_OPCODE  6:0
`define RV_FUNCT3  14:12
`define RV_FUNCT7  31:25
`define RV_FUNCT12 31:20        // also the csr address

//////////////////////////////
// major opcodes
//////////////////////////////
`define RV_OPC_LOAD     7'h03
`define RV_OPC_MISC_MEM 7'h0f
`define RV_OPC_OP_IMM   7'h13
`define RV_OPC_AUIPC    7'h17
`define RV_OPC_STORE    7'h23
`define RV_OPC_OP       7'h33
`define RV_OPC_LUI      7'h37
`define RV_OPC_BRANCH   7'h63
`define RV_OPC_JALR     7'h67
`define RV_OPC_JAL      7'h6f
`define RV_OPC_SYSTEM   7'h73

`define RV_F7_BASE 7'b000_0000  // add, srl and friends
`define RV_F7_ALT  7'b010_0000  // sub, sra

// system funct12 codes
`define RV_F12_ECALL  12'h000
`define RV_F12_EBREAK 12'h001
`define RV_F12_MRET   12'h302
`define RV_F12_DRET   12'h7b2
`define RV_F12_WFI    12'h105

// csr addresses
`define RV_CSR_MSTATUS   12'h300
`define RV_CSR_MIE       12'h304
`define RV_CSR_DCSR      12'h7b0
`define RV_CSR_DPC       12'h7b1
`define RV_CSR_DSCRATCH0 12'h7b2
`define RV_CSR_DSCRATCH1 12'h7b3

`endif
